//--- hdl/tcdmPkg.sv
////////////////////////////////////////////////////////////////////////////
// bank geometry of the word-interleaved memory, fixed at eight banks of
// 32-bit words; consecutive words land in consecutive banks and the byte
// offset below the bank index is ignored by the interconnect
////////////////////////////////////////////////////////////////////////////

package tcdmPkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry constants

  // bank count and the width of its index
  localparam int unsigned NumBanks     = 8;
  localparam int unsigned BankSelWidth = $clog2(NumBanks);

  // word and byte-enable widths
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned WordOffWidth = $clog2(BeWidth);

  // initiator byte address and bank-local word address
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned AddrMemWidth = 10;

  // bits above the bank-local word address, ignored by the banks
  localparam int unsigned UnusedWidth  = AddrWidth - AddrMemWidth - BankSelWidth
                                         - WordOffWidth;

  ////////////////////////////////////////////////////////////////////////////
  // address views

  // field view, top down
  typedef struct packed {
    logic [UnusedWidth-1:0]  unused;
    logic [AddrMemWidth-1:0] memAddr;
    logic [BankSelWidth-1:0] bankSel;
    logic [WordOffWidth-1:0] wordOff;
  } tcdmAddrFields_s;

  // one address word, seen either raw or split into fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    tcdmAddrFields_s      fields;
  } tcdmAddr_u;

endpackage

//--- hdl/tcdmReqIf.sv
////////////////////////////////////////////////////////////////////////////
// per-initiator request bundle; every field is packed and indexed by the
// initiator number, with an already decoded bank index and local address
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tcdmReqIf #(
  parameter int unsigned NumIn = 4
);

  // request side, one entry per initiator
  logic [NumIn-1:0]                              req;
  logic [NumIn-1:0][tcdmPkg::BankSelWidth-1:0]   bankSel;
  logic [NumIn-1:0][tcdmPkg::AddrMemWidth-1:0]   memAddr;
  logic [NumIn-1:0]                              wen;
  logic [NumIn-1:0][tcdmPkg::BeWidth-1:0]        be;
  logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]      wdata;

  // combinational grant back from the bank side
  logic [NumIn-1:0]                              gnt;

  // address decoder produces the request fields
  modport decoder (
    output req, bankSel, memAddr, wen, be, wdata,
    input  gnt
  );

  // bank arbitration consumes them and answers with grants
  modport arbiter (
    input  req, bankSel, memAddr, wen, be, wdata,
    output gnt
  );

  // response side only needs to know what was accepted and where
  modport tracker (
    input  req, gnt, bankSel, wen
  );

endinterface

//--- hdl/reqDecode.sv
////////////////////////////////////////////////////////////////////////////
// address split for every initiator; purely combinational
// initiators must hold req and all fields until granted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reqDecode #(
  parameter int unsigned NumIn = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // initiator side
  input  logic [NumIn-1:0]                        req_i,
  input  logic [NumIn-1:0][tcdmPkg::AddrWidth-1:0] add_i,
  input  logic [NumIn-1:0]                        wen_i,
  input  logic [NumIn-1:0][tcdmPkg::DataWidth-1:0] wdata_i,
  input  logic [NumIn-1:0][tcdmPkg::BeWidth-1:0]   be_i,
  output logic [NumIn-1:0]                        gnt_o,
  // decoded requests towards the banks
  tcdmReqIf.decoder                               reqIf
);

  // fields that pass untouched
  assign reqIf.req   = req_i;
  assign reqIf.wen   = wen_i;
  assign reqIf.be    = be_i;
  assign reqIf.wdata = wdata_i;

  // grants come back already folded per initiator
  assign gnt_o = reqIf.gnt;

  for (genvar i = 0; i < NumIn; i++) begin : gInit
    tcdmPkg::tcdmAddr_u addrView;

    assign addrView.raw = add_i[i];

    // word offset and upper bits are dropped here
    assign reqIf.bankSel[i] = addrView.fields.bankSel;
    assign reqIf.memAddr[i] = addrView.fields.memAddr;

    // a stalled request has to come back unchanged, otherwise the
    // arbiter may forward a different address than the one it granted
    heldReqA: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (req_i[i] && !gnt_o[i]) |=>
        (req_i[i] && $stable(add_i[i]) && $stable(wen_i[i]))
    ) else $error("initiator %0d changed a pending request", i);
  end

endmodule

//--- hdl/bankArbiter.sv
////////////////////////////////////////////////////////////////////////////
// round-robin arbitration per bank, combinational from req to gnt
// all banks share one priority pointer; NumIn must be a power of two
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bankArbiter #(
  parameter int unsigned NumIn = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // decoded initiator requests
  tcdmReqIf.arbiter                                               reqIf,
  // bank side
  output logic [tcdmPkg::NumBanks-1:0]                            req_o,
  input  logic [tcdmPkg::NumBanks-1:0]                            gnt_i,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::AddrMemWidth-1:0] add_o,
  output logic [tcdmPkg::NumBanks-1:0]                            wen_o,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::DataWidth-1:0]    wdata_o,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::BeWidth-1:0]      be_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] rrD;
  logic [IdxWidth-1:0] rrQ;

  // grant of every bank towards every initiator
  logic [NumIn-1:0][tcdmPkg::NumBanks-1:0] gntByIn;

  ////////////////////////////////////////////////////////////////////////////
  // per-bank selection

  for (genvar b = 0; b < tcdmPkg::NumBanks; b++) begin : gBank
    logic [NumIn-1:0]    bankReq;
    logic [IdxWidth-1:0] winIdx;
    logic                found;

    for (genvar i = 0; i < NumIn; i++) begin : gMatch
      assign bankReq[i] = reqIf.req[i] &&
                          (reqIf.bankSel[i] == tcdmPkg::BankSelWidth'(b));
      assign gntByIn[i][b] = found && gnt_i[b] && (winIdx == IdxWidth'(i));
    end

    // first requester at or after the pointer, wrapping around
    always_comb begin
      int unsigned cand;
      found  = 1'b0;
      winIdx = '0;
      cand   = 0;
      for (int unsigned k = 0; k < NumIn; k++) begin
        cand = (32'(rrQ) + k) % NumIn;
        if (!found && bankReq[cand]) begin
          found  = 1'b1;
          winIdx = IdxWidth'(cand);
        end
      end
    end

    // the winner's fields go to the bank
    assign req_o[b]   = found;
    assign add_o[b]   = reqIf.memAddr[winIdx];
    assign wen_o[b]   = reqIf.wen[winIdx];
    assign wdata_o[b] = reqIf.wdata[winIdx];
    assign be_o[b]    = reqIf.be[winIdx];

    // seen from the initiator side after folding: one winner per bank
    oneGntA: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(reqIf.gnt & bankReq)
    ) else $error("bank %0d granted more than one initiator", b);

    // a stalled bank must not leak a grant to any of its requesters
    stallGntA: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !gnt_i[b] |-> ((reqIf.gnt & bankReq) == '0)
    ) else $error("bank %0d stalled but an initiator was granted", b);
  end

  // fold bank grants back to initiators
  for (genvar i = 0; i < NumIn; i++) begin : gFold
    assign reqIf.gnt[i] = |gntByIn[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // shared priority pointer

  // moves on any accepted bank access, wraps at NumIn
  assign rrD = (|(req_o & gnt_i)) ? rrQ + IdxWidth'(1) : rrQ;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rrQ <= '0;
    end else begin
      rrQ <= rrD;
    end
  end

endmodule

//--- hdl/respRouter.sv
////////////////////////////////////////////////////////////////////////////
// response return path; banks must answer exactly MemLatency cycles after
// an accepted access, MemLatency >= 1, one new item per cycle per initiator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module respRouter #(
  parameter int unsigned NumIn       = 4,
  parameter int unsigned MemLatency  = 1,
  parameter bit          WriteRespOn = 1'b1
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // accepted requests, observed
  tcdmReqIf.tracker                                            reqIf,
  // bank read data
  input  logic [tcdmPkg::NumBanks-1:0][tcdmPkg::DataWidth-1:0] rdata_i,
  // initiator responses
  output logic [NumIn-1:0]                                     vld_o,
  output logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]             rdata_o
);

  for (genvar i = 0; i < NumIn; i++) begin : gInit
    logic [MemLatency-1:0]                             vldQ;
    logic [MemLatency-1:0]                             wenQ;
    logic [MemLatency-1:0][tcdmPkg::BankSelWidth-1:0]  bankQ;

    ////////////////////////////////////////////////////////////////////////////
    // latency pipeline

    // stage 0 captures the access in its grant cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vldQ <= '0;
      end else begin
        vldQ[0] <= reqIf.req[i] && reqIf.gnt[i];
        for (int unsigned s = 1; s < MemLatency; s++) begin
          vldQ[s] <= vldQ[s-1];
        end
      end
    end

    // bank index and write flag travel alongside the valid bit
    always_ff @(posedge clk_i) begin
      bankQ[0] <= reqIf.bankSel[i];
      wenQ[0]  <= reqIf.wen[i];
      for (int unsigned s = 1; s < MemLatency; s++) begin
        bankQ[s] <= bankQ[s-1];
        wenQ[s]  <= wenQ[s-1];
      end
    end

    ////////////////////////////////////////////////////////////////////////////
    // far end

    // writes only answer when write responses are enabled
    assign vld_o[i] = vldQ[MemLatency-1] &&
                      (WriteRespOn || !wenQ[MemLatency-1]);

    // pick the bank this item was sent to
    assign rdata_o[i] = rdata_i[bankQ[MemLatency-1]];
  end

  // nothing may come back before the first access can have been granted
  quietInResetA: assert property (
    @(posedge clk_i) !rst_ni |-> (vld_o == '0)
  ) else $error("response valid raised during reset");

endmodule

//--- hdl/tcdmInterconnect.sv
////////////////////////////////////////////////////////////////////////////
// word-interleaved crossbar from NumIn initiators to eight banks
// gnt_o is combinational from req_i/add_i/gnt_i; vld_o follows a grant
// after MemLatency cycles, for writes only when WriteRespOn is set
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdmInterconnect #(
  parameter int unsigned NumIn       = 4,
  parameter int unsigned MemLatency  = 1,
  parameter bit          WriteRespOn = 1'b1
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // initiator side
  input  logic [NumIn-1:0]                                        req_i,
  input  logic [NumIn-1:0][tcdmPkg::AddrWidth-1:0]                add_i,
  input  logic [NumIn-1:0]                                        wen_i,
  input  logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]                wdata_i,
  input  logic [NumIn-1:0][tcdmPkg::BeWidth-1:0]                  be_i,
  output logic [NumIn-1:0]                                        gnt_o,
  output logic [NumIn-1:0]                                        vld_o,
  output logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]                rdata_o,
  // bank side
  output logic [tcdmPkg::NumBanks-1:0]                            req_o,
  input  logic [tcdmPkg::NumBanks-1:0]                            gnt_i,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::AddrMemWidth-1:0] add_o,
  output logic [tcdmPkg::NumBanks-1:0]                            wen_o,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::DataWidth-1:0]    wdata_o,
  output logic [tcdmPkg::NumBanks-1:0][tcdmPkg::BeWidth-1:0]      be_o,
  input  logic [tcdmPkg::NumBanks-1:0][tcdmPkg::DataWidth-1:0]    rdata_i
);

  // decoded requests shared by all three stages
  tcdmReqIf #(
    .NumIn ( NumIn )
  ) reqIf ();

  // address split and grant fold
  reqDecode #(
    .NumIn   ( NumIn   )
  ) decode_i (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .add_i   ( add_i   ),
    .wen_i   ( wen_i   ),
    .wdata_i ( wdata_i ),
    .be_i    ( be_i    ),
    .gnt_o   ( gnt_o   ),
    .reqIf   ( reqIf   )
  );

  // per-bank round robin
  bankArbiter #(
    .NumIn   ( NumIn   )
  ) arbiter_i (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .reqIf   ( reqIf   ),
    .req_o   ( req_o   ),
    .gnt_i   ( gnt_i   ),
    .add_o   ( add_o   ),
    .wen_o   ( wen_o   ),
    .wdata_o ( wdata_o ),
    .be_o    ( be_o    )
  );

  // response return
  respRouter #(
    .NumIn       ( NumIn       ),
    .MemLatency  ( MemLatency  ),
    .WriteRespOn ( WriteRespOn )
  ) router_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reqIf       ( reqIf       ),
    .rdata_i     ( rdata_i     ),
    .vld_o       ( vld_o       ),
    .rdata_o     ( rdata_o     )
  );

endmodule

//--- verif/tcdmChecker.sv
////////////////////////////////////////////////////////////////////////////
// passive checker sampling on the falling edge, where every DUT port is
// stable; predicts grants, bank-side fields and responses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdmChecker #(
  parameter int unsigned NumIn       = 4,
  parameter int unsigned MemLatency  = 1,
  parameter bit          WriteRespOn = 1'b1
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [NumIn-1:0]                                        req_i,
  input  logic [NumIn-1:0][tcdmPkg::AddrWidth-1:0]                add_i,
  input  logic [NumIn-1:0]                                        wen_i,
  input  logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]                wdata_i,
  input  logic [NumIn-1:0][tcdmPkg::BeWidth-1:0]                  be_i,
  input  logic [NumIn-1:0]                                        gnt_o,
  input  logic [NumIn-1:0]                                        vld_o,
  input  logic [NumIn-1:0][tcdmPkg::DataWidth-1:0]                rdata_o,
  input  logic [tcdmPkg::NumBanks-1:0]                            req_o,
  input  logic [tcdmPkg::NumBanks-1:0]                            gnt_i,
  input  logic [tcdmPkg::NumBanks-1:0][tcdmPkg::AddrMemWidth-1:0] add_o,
  input  logic [tcdmPkg::NumBanks-1:0]                            wen_o,
  input  logic [tcdmPkg::NumBanks-1:0][tcdmPkg::DataWidth-1:0]    wdata_o,
  input  logic [tcdmPkg::NumBanks-1:0][tcdmPkg::BeWidth-1:0]      be_o,
  output int                                                      errCount_o,
  output int                                                      checkCount_o,
  output int                                                      pending_o
);

  typedef struct packed {
    int          due;
    logic        wr;
    logic [31:0] data;
  } resp_t;

  // reference memory, missing keys read as zero
  logic [31:0] refMem [int];
  resp_t       respQ [NumIn][$];
  int          ptr    = 0;
  int          cycle  = 0;
  int          errs   = 0;
  int          checks = 0;
  int          pend   = 0;

  assign errCount_o   = errs;
  assign checkCount_o = checks;
  assign pending_o    = pend;

  function automatic int bankOf(input logic [31:0] a);
    tcdmPkg::tcdmAddr_u v;
    v.raw = a;
    return int'(v.fields.bankSel);
  endfunction

  function automatic int wordOf(input logic [31:0] a);
    tcdmPkg::tcdmAddr_u v;
    v.raw = a;
    return int'(v.fields.memAddr);
  endfunction

  // byte-enabled merge of a store into a stored word
  function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                             input logic [31:0] wd,
                                             input logic [3:0]  be);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) res[8*k +: 8] = wd[8*k +: 8];
    end
    return res;
  endfunction

  task automatic checkValue(input string name, input int idx,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    checks++;
    if (expVal !== actVal) begin
      errs++;
      $display("FAILED %s[%0d] expected 0x%h got 0x%h at cycle %0d",
               name, idx, expVal, actVal, cycle);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-cycle prediction

  always @(negedge clk_i) begin
    logic [NumIn-1:0] expGnt;
    logic             expV;
    resp_t            item;
    logic [31:0]      old;
    int               win;
    int               c;
    int               key;
    if (rst_ni) begin
      cycle++;
      // responses due this cycle
      for (int i = 0; i < int'(NumIn); i++) begin
        expV = (respQ[i].size() != 0) && (respQ[i][0].due == cycle);
        checkValue("vld_o", i, 32'(expV), 32'(vld_o[i]));
        if (expV) begin
          item = respQ[i].pop_front();
          if (!item.wr) checkValue("rdata_o", i, item.data, rdata_o[i]);
        end
      end
      // round-robin winner per bank
      expGnt = '0;
      for (int b = 0; b < int'(tcdmPkg::NumBanks); b++) begin
        win = -1;
        for (int k = 0; k < int'(NumIn); k++) begin
          c = (ptr + k) % int'(NumIn);
          if (win < 0 && req_i[c] && bankOf(add_i[c]) == b) win = c;
        end
        checkValue("req_o", b, 32'(win >= 0), 32'(req_o[b]));
        if (win >= 0) begin
          checkValue("add_o", b, 32'(wordOf(add_i[win])), 32'(add_o[b]));
          checkValue("wen_o", b, 32'(wen_i[win]), 32'(wen_o[b]));
          checkValue("wdata_o", b, wdata_i[win], wdata_o[b]);
          checkValue("be_o", b, 32'(be_i[win]), 32'(be_o[b]));
          if (gnt_i[b]) expGnt[win] = 1'b1;
        end
      end
      // grants and the accesses they accept
      for (int i = 0; i < int'(NumIn); i++) begin
        checkValue("gnt_o", i, 32'(expGnt[i]), 32'(gnt_o[i]));
        if (expGnt[i]) begin
          key = bankOf(add_i[i]) * 1024 + wordOf(add_i[i]);
          old = refMem.exists(key) ? refMem[key] : 32'h0;
          item.due  = cycle + int'(MemLatency);
          item.wr   = wen_i[i];
          item.data = old;
          if (wen_i[i]) refMem[key] = mergeBytes(old, wdata_i[i], be_i[i]);
          if (!wen_i[i] || WriteRespOn) respQ[i].push_back(item);
        end
      end
      if (|(req_o & gnt_i)) ptr = (ptr + 1) % int'(NumIn);
      pend = 0;
      for (int i = 0; i < int'(NumIn); i++) pend += respQ[i].size();
    end
  end

endmodule

//--- verif/tcdmTb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the interconnect with default parameters; banks are
// modelled here with byte-enabled writes and MemLatency read delay
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcdmTb;

  localparam int unsigned NumIn         = 4;
  localparam int unsigned MemLatency    = 1;
  localparam bit          WriteRespOn   = 1'b1;
  localparam int          NumBanks      = int'(tcdmPkg::NumBanks);
  localparam int          NumRows       = 11;
  localparam int          TimeoutCycles = 20 * NumRows * int'(NumIn);

  logic                                    clk_i;
  logic                                    rst_ni;
  logic [NumIn-1:0]                        req_i;
  logic [NumIn-1:0][31:0]                  add_i;
  logic [NumIn-1:0]                        wen_i;
  logic [NumIn-1:0][31:0]                  wdata_i;
  logic [NumIn-1:0][3:0]                   be_i;
  logic [NumIn-1:0]                        gnt_o;
  logic [NumIn-1:0]                        vld_o;
  logic [NumIn-1:0][31:0]                  rdata_o;
  logic [NumBanks-1:0]                     req_o;
  logic [NumBanks-1:0]                     bankGnt;
  logic [NumBanks-1:0][9:0]                add_o;
  logic [NumBanks-1:0]                     wen_o;
  logic [NumBanks-1:0][31:0]               wdata_o;
  logic [NumBanks-1:0][3:0]                be_o;
  logic [NumBanks-1:0][31:0]               bankRdata;
  int                                      errCount;
  int                                      checkCount;
  int                                      pending;
  int                                      cycles = 0;

  // stimulus table, one row per step
  logic [NumIn-1:0]       tReq   [NumRows];
  logic [NumIn-1:0][31:0] tAdd   [NumRows];
  logic [NumIn-1:0]       tWen   [NumRows];
  logic [NumIn-1:0][3:0]  tBe    [NumRows];
  logic [NumIn-1:0][31:0] tWdata [NumRows];
  logic [NumBanks-1:0]    tMask  [NumRows];
  int                     tStall [NumRows];

  // bank models, read path starts out at zero
  logic [31:0]                  bankMem   [NumBanks][1024];
  logic [31:0]                  readLatch [NumBanks] = '{default: '0};
  logic [MemLatency-1:0][31:0]  bankPipe  [NumBanks] = '{default: '0};

  tcdmInterconnect #(
    .NumIn       ( NumIn       ),
    .MemLatency  ( MemLatency  ),
    .WriteRespOn ( WriteRespOn )
  ) dut_i (
    .clk_i, .rst_ni, .req_i, .add_i, .wen_i, .wdata_i, .be_i,
    .gnt_o, .vld_o, .rdata_o, .req_o, .gnt_i ( bankGnt ),
    .add_o, .wen_o, .wdata_o, .be_o, .rdata_i ( bankRdata )
  );

  tcdmChecker #(
    .NumIn       ( NumIn       ),
    .MemLatency  ( MemLatency  ),
    .WriteRespOn ( WriteRespOn )
  ) checker_i (
    .clk_i, .rst_ni, .req_i, .add_i, .wen_i, .wdata_i, .be_i,
    .gnt_o, .vld_o, .rdata_o, .req_o, .gnt_i ( bankGnt ),
    .add_o, .wen_o, .wdata_o, .be_o,
    .errCount_o ( errCount ), .checkCount_o ( checkCount ), .pending_o ( pending )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bank models: access on the falling edge, data out after MemLatency

  always @(negedge clk_i) begin
    logic [31:0] word;
    for (int b = 0; b < NumBanks; b++) begin
      if (!rst_ni) begin
        for (int w = 0; w < 1024; w++) bankMem[b][w] = 32'h0;
        readLatch[b] <= 32'h0;
      end else if (req_o[b] && bankGnt[b]) begin
        word = bankMem[b][add_o[b]];
        readLatch[b] <= word;
        for (int k = 0; k < 4; k++) begin
          if (wen_o[b] && be_o[b][k]) word[8*k +: 8] = wdata_o[b][8*k +: 8];
        end
        bankMem[b][add_o[b]] = word;
      end
    end
  end

  always @(posedge clk_i) begin
    for (int b = 0; b < NumBanks; b++) begin
      bankPipe[b][0] <= readLatch[b];
      for (int s = 1; s < int'(MemLatency); s++) bankPipe[b][s] <= bankPipe[b][s-1];
    end
  end

  always_comb begin
    for (int b = 0; b < NumBanks; b++) bankRdata[b] = bankPipe[b][MemLatency-1];
  end

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic setReq(input int r, input int i, input logic w, input int bank,
                        input int word, input logic [3:0] be, input logic [31:0] d);
    tReq[r][i]   = 1'b1;
    tWen[r][i]   = w;
    tAdd[r][i]   = (32'(word) << 5) | (32'(bank) << 2);
    tBe[r][i]    = be;
    tWdata[r][i] = d;
  endtask

  task automatic buildTable();
    for (int r = 0; r < NumRows; r++) begin
      tReq[r] = '0;
      tAdd[r] = '0;
      tWen[r] = '0;
      tBe[r] = '0;
      tWdata[r] = '0;
      tMask[r] = '1;
      tStall[r] = 0;
    end
    // routing writes, then reads incl. a never written word
    setReq(0, 0, 1'b1, 1, 5, 4'hf, 32'ha5a5_0001);
    setReq(0, 1, 1'b1, 2, 7, 4'hf, 32'h1234_5678);
    setReq(0, 2, 1'b1, 3, 0, 4'hf, 32'hdead_beef);
    setReq(0, 3, 1'b1, 4, 9, 4'hf, 32'h0bad_f00d);
    setReq(1, 0, 1'b0, 1, 5, 4'hf, 32'h0);
    setReq(1, 1, 1'b0, 2, 7, 4'hf, 32'h0);
    setReq(1, 2, 1'b0, 3, 0, 4'hf, 32'h0);
    setReq(1, 3, 1'b0, 5, 3, 4'hf, 32'h0);
    // all four on bank 0
    for (int i = 0; i < int'(NumIn); i++) begin
      setReq(2, i, 1'b1, 0, i + 1, 4'hf, 32'hc0de_0000 + 32'(i));
      setReq(3, i, 1'b0, 0, i + 1, 4'hf, 32'h0);
    end
    // partial store and read back
    setReq(4, 1, 1'b1, 1, 5, 4'b0101, 32'hffff_ffff);
    setReq(5, 1, 1'b0, 1, 5, 4'hf, 32'h0);
    // bank 6 stalled for three cycles, bank 7 goes on
    setReq(6, 0, 1'b1, 6, 1, 4'hf, 32'h6666_0001);
    setReq(6, 1, 1'b1, 7, 1, 4'hf, 32'h7777_0001);
    tMask[6]  = 8'b1011_1111;
    tStall[6] = 3;
    setReq(7, 2, 1'b0, 6, 1, 4'hf, 32'h0);
    setReq(7, 3, 1'b0, 7, 1, 4'hf, 32'h0);
    // back-to-back reads from one initiator
    setReq(8, 0, 1'b0, 1, 5, 4'hf, 32'h0);
    setReq(9, 0, 1'b0, 2, 7, 4'hf, 32'h0);
    setReq(10, 0, 1'b0, 0, 3, 4'hf, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus loop

  initial begin
    logic [NumIn-1:0] pendingReq;
    logic [NumIn-1:0] granted;
    int               cyc;
    rst_ni  = 1'b0;
    req_i   = '0;
    add_i   = '0;
    wen_i   = '0;
    wdata_i = '0;
    be_i    = '0;
    bankGnt = '1;
    buildTable();
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    for (int r = 0; r < NumRows; r++) begin
      req_i      = tReq[r];
      add_i      = tAdd[r];
      wen_i      = tWen[r];
      wdata_i    = tWdata[r];
      be_i       = tBe[r];
      pendingReq = tReq[r];
      cyc        = 0;
      bankGnt    = (tStall[r] > 0) ? tMask[r] : '1;
      do begin
        @(negedge clk_i);
        granted = pendingReq & gnt_o;
        @(posedge clk_i);
        #1;
        pendingReq = pendingReq & ~granted;
        req_i      = pendingReq;
        cyc++;
        bankGnt    = (cyc < tStall[r]) ? tMask[r] : '1;
      end while (pendingReq != '0);
    end
    req_i = '0;
    // drain outstanding responses
    @(negedge clk_i);
    while (pending != 0) @(negedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("checks: %0d  errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
hdl/tcdmPkg.sv
hdl/tcdmReqIf.sv
hdl/reqDecode.sv
hdl/bankArbiter.sv
hdl/respRouter.sv
hdl/tcdmInterconnect.sv
verif/tcdmChecker.sv
verif/tcdmTb.sv

//--- run.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator.
# Pass or fail comes from the simulation log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tcdmTb \
  -o tcdmTb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/tcdmTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
